//--- verilog/msix_pkg.sv
/*
 * msix package
 * table sizes, register map and enums shared by the MSI-X message generator
 */
package msix_pkg;

   // default sizes, msix_top passes the real values down
   localparam int DEF_NUM_PF_VEC = 7;
   localparam int DEF_NUM_VF_VEC = 5;
   localparam int DEF_VEC_W      = 3;   // must cover the larger count

   //------------------------------------------------------------
   // register map, one 64-bit word per address
   //------------------------------------------------------------
   localparam int CSR_ADDR_W = 6;

   // entry n: word 2n is the message address, word 2n+1 data and mask
   localparam logic [CSR_ADDR_W-1:0] VF_TABLE_BASE = 6'd16;
   localparam logic [CSR_ADDR_W-1:0] PBA_PF_ADDR   = 6'd32;  // read only
   localparam logic [CSR_ADDR_W-1:0] PBA_VF_ADDR   = 6'd33;  // read only
   localparam logic [CSR_ADDR_W-1:0] CTRL_ADDR     = 6'd34;

   localparam int CTRL_EN_BIT    = 0;
   localparam int CTRL_FMASK_BIT = 1;
   localparam int CTL_MASK_BIT   = 32;  // above the 32 data bits

   //------------------------------------------------------------
   // enums
   //------------------------------------------------------------
   typedef enum logic [1:0] {
      ST_DISABLED = 2'd0,
      ST_ACTIVE   = 2'd1,
      ST_FMASKED  = 2'd2
   } msix_state_e;

   typedef enum logic {
      SRC_PF = 1'b0,
      SRC_VF = 1'b1
   } msix_src_e;

endpackage

//--- verilog/msix_lookup_if.sv
/*
 * lookup request interface
 * carries one issued vector per cycle from the controller to the table lookup
 */
interface msix_lookup_if
   import msix_pkg::*;
#(
   parameter int VEC_W = DEF_VEC_W
) ();

   logic             issue;  // single cycle strobe
   msix_src_e        src;
   logic [VEC_W-1:0] vec;

   modport ctrl (
      output issue,
      output src,
      output vec
   );

   modport lookup (
      input issue,
      input src,
      input vec
   );

endinterface

//--- verilog/msix_csr.sv
/*
 * msix register block
 * PF and VF vector tables, control register and registered read path.
 * reads also return the live pending bit arrays.
 */
module msix_csr
   import msix_pkg::*;
#(
   parameter int NUM_PF_VEC = DEF_NUM_PF_VEC,
   parameter int NUM_VF_VEC = DEF_NUM_VF_VEC
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       i_csr_wr,
   input  logic                       i_csr_rd,
   input  logic [CSR_ADDR_W-1:0]      i_csr_addr,
   input  logic [63:0]                i_csr_wdata,
   input  logic [NUM_PF_VEC-1:0]      i_pf_pending,
   input  logic [NUM_VF_VEC-1:0]      i_vf_pending,
   output logic [63:0]                o_csr_rdata,
   output logic                       o_csr_rvalid,
   output logic [NUM_PF_VEC*64-1:0]   o_pf_addr,
   output logic [NUM_PF_VEC*32-1:0]   o_pf_data,
   output logic [NUM_PF_VEC-1:0]      o_pf_mask,
   output logic [NUM_VF_VEC*64-1:0]   o_vf_addr,
   output logic [NUM_VF_VEC*32-1:0]   o_vf_data,
   output logic [NUM_VF_VEC-1:0]      o_vf_mask,
   output logic                       o_enable,
   output logic                       o_fmask
);

   // PF entries first, VF entries follow in the same storage
   localparam int NUM_ENT = NUM_PF_VEC + NUM_VF_VEC;
   localparam int ENT_W   = $clog2(NUM_ENT);

   logic [63:0]       tbl_addr [NUM_ENT];
   logic [32:0]       tbl_ctl  [NUM_ENT];   // {mask, data}
   logic [1:0]        ctrl_q;
   logic              ent_hit;
   logic              ent_ctl;              // odd word
   logic [ENT_W-1:0]  ent_idx;
   logic [63:0]       rd_word;

   //------------------------------------------------------------
   // address decode, shared by write and read
   //------------------------------------------------------------
   always_comb begin
      ent_hit = 1'b0;
      ent_ctl = i_csr_addr[0];
      ent_idx = '0;
      if (int'(i_csr_addr) < 2 * NUM_PF_VEC) begin
         ent_hit = 1'b1;
         ent_idx = ENT_W'(i_csr_addr >> 1);
      end else if (i_csr_addr >= VF_TABLE_BASE &&
                   int'(i_csr_addr - VF_TABLE_BASE) < 2 * NUM_VF_VEC) begin
         ent_hit = 1'b1;
         ent_idx = ENT_W'(NUM_PF_VEC) + ENT_W'((i_csr_addr - VF_TABLE_BASE) >> 1);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int e = 0; e < NUM_ENT; e++) begin
            tbl_addr[e] <= '0;
            tbl_ctl[e]  <= '0;
         end
         ctrl_q <= '0;   // disabled, not function masked
      end else if (i_csr_wr) begin
         if (ent_hit && !ent_ctl) begin
            tbl_addr[ent_idx] <= i_csr_wdata;
         end
         if (ent_hit && ent_ctl) begin
            tbl_ctl[ent_idx] <= i_csr_wdata[CTL_MASK_BIT:0];
         end
         if (i_csr_addr == CTRL_ADDR) begin
            ctrl_q <= i_csr_wdata[1:0];
         end
      end
   end

   //------------------------------------------------------------
   // read mux, one cycle latency
   //------------------------------------------------------------
   always_comb begin
      rd_word = '0;   // unmapped reads as zero
      if (ent_hit) begin
         rd_word = ent_ctl ? 64'(tbl_ctl[ent_idx]) : tbl_addr[ent_idx];
      end else begin
         case (i_csr_addr)
            PBA_PF_ADDR: rd_word = 64'(i_pf_pending);
            PBA_VF_ADDR: rd_word = 64'(i_vf_pending);
            CTRL_ADDR:   rd_word = 64'(ctrl_q);
            default:     rd_word = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_csr_rvalid <= 1'b0;
      end else begin
         o_csr_rvalid <= i_csr_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (i_csr_rd) begin
         o_csr_rdata <= rd_word;
      end
   end

   // flatten tables for the lookup and controller
   for (genvar v = 0; v < NUM_PF_VEC; v++) begin : g_pf
      assign o_pf_addr[v*64 +: 64] = tbl_addr[v];
      assign o_pf_data[v*32 +: 32] = tbl_ctl[v][31:0];
      assign o_pf_mask[v]          = tbl_ctl[v][CTL_MASK_BIT];
   end

   for (genvar v = 0; v < NUM_VF_VEC; v++) begin : g_vf
      assign o_vf_addr[v*64 +: 64] = tbl_addr[NUM_PF_VEC + v];
      assign o_vf_data[v*32 +: 32] = tbl_ctl[NUM_PF_VEC + v][31:0];
      assign o_vf_mask[v]          = tbl_ctl[NUM_PF_VEC + v][CTL_MASK_BIT];
   end

   assign o_enable = ctrl_q[CTRL_EN_BIT];
   assign o_fmask  = ctrl_q[CTRL_FMASK_BIT];

endmodule

//--- verilog/msix_pending.sv
/*
 * msix pending bit arrays
 * one bit per PF and VF vector, set by requests and cleared on issue
 */
module msix_pending
   import msix_pkg::*;
#(
   parameter int NUM_PF_VEC = DEF_NUM_PF_VEC,
   parameter int NUM_VF_VEC = DEF_NUM_VF_VEC,
   parameter int VEC_W      = DEF_VEC_W
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  i_intr_valid,
   input  logic                  i_intr_vf,
   input  logic [VEC_W-1:0]      i_intr_vec,
   input  logic                  i_clr,
   input  msix_src_e             i_clr_src,
   input  logic [VEC_W-1:0]      i_clr_vec,
   output logic [NUM_PF_VEC-1:0] o_pf_pending,
   output logic [NUM_VF_VEC-1:0] o_vf_pending
);

   logic [NUM_PF_VEC-1:0] pf_set, pf_clr;
   logic [NUM_VF_VEC-1:0] vf_set, vf_clr;

   // decode request and clear into one-hot masks
   always_comb begin
      pf_set = '0;
      vf_set = '0;
      pf_clr = '0;
      vf_clr = '0;
      if (i_intr_valid) begin
         if (!i_intr_vf && int'(i_intr_vec) < NUM_PF_VEC) begin
            pf_set[i_intr_vec] = 1'b1;
         end
         if (i_intr_vf && int'(i_intr_vec) < NUM_VF_VEC) begin
            vf_set[i_intr_vec] = 1'b1;
         end
         // out of range vectors fall through, dropped
      end
      if (i_clr) begin
         if (i_clr_src == SRC_PF) pf_clr[i_clr_vec] = 1'b1;
         else                     vf_clr[i_clr_vec] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_pf_pending <= '0;
         o_vf_pending <= '0;
      end else begin
         // set after clear so a new request re-arms the bit
         o_pf_pending <= (o_pf_pending & ~pf_clr) | pf_set;
         o_vf_pending <= (o_vf_pending & ~vf_clr) | vf_set;
      end
   end

endmodule

//--- verilog/msix_ctrl.sv
/*
 * msix controller
 * tracks enable and function mask, picks the lowest eligible pending vector
 * (PF before VF) and issues it to the table lookup
 */
module msix_ctrl
   import msix_pkg::*;
#(
   parameter int NUM_PF_VEC = DEF_NUM_PF_VEC,
   parameter int NUM_VF_VEC = DEF_NUM_VF_VEC,
   parameter int VEC_W      = DEF_VEC_W
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [NUM_PF_VEC-1:0] i_pf_pending,
   input  logic [NUM_VF_VEC-1:0] i_vf_pending,
   input  logic [NUM_PF_VEC-1:0] i_pf_mask,
   input  logic [NUM_VF_VEC-1:0] i_vf_mask,
   input  logic                  i_enable,
   input  logic                  i_fmask,
   output logic                  o_clr,
   output msix_src_e             o_clr_src,
   output logic [VEC_W-1:0]      o_clr_vec,
   msix_lookup_if.ctrl           lk
);

   msix_state_e           state, state_nxt;
   logic [NUM_PF_VEC-1:0] pf_elig;
   logic [NUM_VF_VEC-1:0] vf_elig;
   logic                  pick_vld;
   msix_src_e             pick_src;
   logic [VEC_W-1:0]      pick_vec;

   //------------------------------------------------------------
   // state machine
   //------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         ST_DISABLED: begin
            if (i_enable) state_nxt = i_fmask ? ST_FMASKED : ST_ACTIVE;
         end
         ST_ACTIVE: begin
            if (!i_enable)    state_nxt = ST_DISABLED;
            else if (i_fmask) state_nxt = ST_FMASKED;  // fmask wins
         end
         ST_FMASKED: begin
            if (!i_enable)     state_nxt = ST_DISABLED;
            else if (!i_fmask) state_nxt = ST_ACTIVE;
         end
         default: state_nxt = ST_DISABLED;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) state <= ST_DISABLED;
      else        state <= state_nxt;
   end

   //------------------------------------------------------------
   // fixed priority pick
   //------------------------------------------------------------
   assign pf_elig = i_pf_pending & ~i_pf_mask;
   assign vf_elig = i_vf_pending & ~i_vf_mask;

   always_comb begin
      pick_vld = 1'b0;
      pick_src = SRC_PF;
      pick_vec = '0;
      // scan downward so the lowest index is kept, PF scanned last
      for (int v = NUM_VF_VEC - 1; v >= 0; v--) begin
         if (vf_elig[v]) begin
            pick_vld = 1'b1;
            pick_src = SRC_VF;
            pick_vec = VEC_W'(v);
         end
      end
      for (int v = NUM_PF_VEC - 1; v >= 0; v--) begin
         if (pf_elig[v]) begin
            pick_vld = 1'b1;
            pick_src = SRC_PF;
            pick_vec = VEC_W'(v);
         end
      end
   end

   // clear lands on the same edge that registers the issue
   assign o_clr     = pick_vld && (state == ST_ACTIVE);
   assign o_clr_src = pick_src;
   assign o_clr_vec = pick_vec;

   always_ff @(posedge clk) begin
      if (!rst_n) lk.issue <= 1'b0;
      else        lk.issue <= o_clr;
   end

   always_ff @(posedge clk) begin
      if (o_clr) begin
         lk.src <= pick_src;
         lk.vec <= pick_vec;
      end
   end

endmodule

//--- verilog/msix_table_lookup.sv
/*
 * msix table lookup
 * stage 1 selects the PF or VF entry, stage 2 registers the message strobe
 */
module msix_table_lookup
   import msix_pkg::*;
#(
   parameter int NUM_PF_VEC = DEF_NUM_PF_VEC,
   parameter int NUM_VF_VEC = DEF_NUM_VF_VEC,
   parameter int VEC_W      = DEF_VEC_W
) (
   input  logic                     clk,
   input  logic                     rst_n,
   msix_lookup_if.lookup            lk,
   input  logic [NUM_PF_VEC*64-1:0] i_pf_addr,
   input  logic [NUM_PF_VEC*32-1:0] i_pf_data,
   input  logic [NUM_VF_VEC*64-1:0] i_vf_addr,
   input  logic [NUM_VF_VEC*32-1:0] i_vf_data,
   output logic                     o_msg_valid,
   output logic [63:0]              o_msg_addr,
   output logic [31:0]              o_msg_data,
   output logic                     o_msg_vf,
   output logic [VEC_W-1:0]         o_msg_vec
);

   logic [63:0]      sel_addr;
   logic [31:0]      sel_data;
   logic             s1_vld;
   msix_src_e        s1_src;
   logic [VEC_W-1:0] s1_vec;
   logic [63:0]      s1_addr;
   logic [31:0]      s1_data;

   // entry select, zero for a vector past the table end
   always_comb begin
      sel_addr = '0;
      sel_data = '0;
      if (lk.src == SRC_VF) begin
         if (int'(lk.vec) < NUM_VF_VEC) begin
            sel_addr = i_vf_addr[int'(lk.vec) * 64 +: 64];
            sel_data = i_vf_data[int'(lk.vec) * 32 +: 32];
         end
      end else if (int'(lk.vec) < NUM_PF_VEC) begin
         sel_addr = i_pf_addr[int'(lk.vec) * 64 +: 64];
         sel_data = i_pf_data[int'(lk.vec) * 32 +: 32];
      end
   end

   //------------------------------------------------------------
   // stage 1 and stage 2
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_vld      <= 1'b0;
         o_msg_valid <= 1'b0;
      end else begin
         s1_vld      <= lk.issue;
         o_msg_valid <= s1_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (lk.issue) begin
         s1_src  <= lk.src;
         s1_vec  <= lk.vec;
         s1_addr <= sel_addr;   // table contents as of this edge
         s1_data <= sel_data;
      end
      if (s1_vld) begin
         o_msg_addr <= s1_addr;
         o_msg_data <= s1_data;
         o_msg_vf   <= (s1_src == SRC_VF);
         o_msg_vec  <= s1_vec;
      end
   end

endmodule

//--- verilog/msix_top.sv
/*
 * msix top
 * MSI-X message generator for one PF and one VF, register port and
 * request strobes in, one message strobe out
 */
module msix_top
   import msix_pkg::*;
#(
   parameter int NUM_PF_VEC = DEF_NUM_PF_VEC,
   parameter int NUM_VF_VEC = DEF_NUM_VF_VEC,
   parameter int VEC_W      = DEF_VEC_W
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // register port
   input  logic                  i_csr_wr,
   input  logic                  i_csr_rd,
   input  logic [CSR_ADDR_W-1:0] i_csr_addr,
   input  logic [63:0]           i_csr_wdata,
   output logic [63:0]           o_csr_rdata,
   output logic                  o_csr_rvalid,
   // interrupt requests
   input  logic                  i_intr_valid,
   input  logic                  i_intr_vf,
   input  logic [VEC_W-1:0]      i_intr_vec,
   // message output, no back-pressure
   output logic                  o_msg_valid,
   output logic [63:0]           o_msg_addr,
   output logic [31:0]           o_msg_data,
   output logic                  o_msg_vf,
   output logic [VEC_W-1:0]      o_msg_vec
);

   logic [NUM_PF_VEC-1:0]    pf_pending, pf_mask;
   logic [NUM_VF_VEC-1:0]    vf_pending, vf_mask;
   logic [NUM_PF_VEC*64-1:0] pf_addr;
   logic [NUM_PF_VEC*32-1:0] pf_data;
   logic [NUM_VF_VEC*64-1:0] vf_addr;
   logic [NUM_VF_VEC*32-1:0] vf_data;
   logic                     enable, fmask;
   logic                     clr;
   msix_src_e                clr_src;
   logic [VEC_W-1:0]         clr_vec;

   msix_lookup_if #(.VEC_W(VEC_W)) lk_if ();

   msix_csr #(
      .NUM_PF_VEC (NUM_PF_VEC),
      .NUM_VF_VEC (NUM_VF_VEC)
   ) msix_csr_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_csr_wr     (i_csr_wr),
      .i_csr_rd     (i_csr_rd),
      .i_csr_addr   (i_csr_addr),
      .i_csr_wdata  (i_csr_wdata),
      .i_pf_pending (pf_pending),
      .i_vf_pending (vf_pending),
      .o_csr_rdata  (o_csr_rdata),
      .o_csr_rvalid (o_csr_rvalid),
      .o_pf_addr    (pf_addr),
      .o_pf_data    (pf_data),
      .o_pf_mask    (pf_mask),
      .o_vf_addr    (vf_addr),
      .o_vf_data    (vf_data),
      .o_vf_mask    (vf_mask),
      .o_enable     (enable),
      .o_fmask      (fmask)
   );

   msix_pending #(
      .NUM_PF_VEC (NUM_PF_VEC),
      .NUM_VF_VEC (NUM_VF_VEC),
      .VEC_W      (VEC_W)
   ) msix_pending_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_intr_valid (i_intr_valid),
      .i_intr_vf    (i_intr_vf),
      .i_intr_vec   (i_intr_vec),
      .i_clr        (clr),
      .i_clr_src    (clr_src),
      .i_clr_vec    (clr_vec),
      .o_pf_pending (pf_pending),
      .o_vf_pending (vf_pending)
   );

   msix_ctrl #(
      .NUM_PF_VEC (NUM_PF_VEC),
      .NUM_VF_VEC (NUM_VF_VEC),
      .VEC_W      (VEC_W)
   ) msix_ctrl_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_pf_pending (pf_pending),
      .i_vf_pending (vf_pending),
      .i_pf_mask    (pf_mask),
      .i_vf_mask    (vf_mask),
      .i_enable     (enable),
      .i_fmask      (fmask),
      .o_clr        (clr),
      .o_clr_src    (clr_src),
      .o_clr_vec    (clr_vec),
      .lk           (lk_if.ctrl)
   );

   msix_table_lookup #(
      .NUM_PF_VEC (NUM_PF_VEC),
      .NUM_VF_VEC (NUM_VF_VEC),
      .VEC_W      (VEC_W)
   ) msix_table_lookup_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .lk          (lk_if.lookup),
      .i_pf_addr   (pf_addr),
      .i_pf_data   (pf_data),
      .i_vf_addr   (vf_addr),
      .i_vf_data   (vf_data),
      .o_msg_valid (o_msg_valid),
      .o_msg_addr  (o_msg_addr),
      .o_msg_data  (o_msg_data),
      .o_msg_vf    (o_msg_vf),
      .o_msg_vec   (o_msg_vec)
   );

endmodule

//--- tb/msix_assert.sv
/*
 * msix bound checks
 * message shut-off after disable or function mask, read latency,
 * vector range and a quiet output right after reset
 */
module msix_assert
   import msix_pkg::*;
#(
   parameter int NUM_PF_VEC = DEF_NUM_PF_VEC,
   parameter int NUM_VF_VEC = DEF_NUM_VF_VEC,
   parameter int VEC_W      = DEF_VEC_W
) (
   input logic             clk,
   input logic             rst_n,
   input logic             i_enable,
   input logic             i_fmask,
   input logic             i_csr_rd,
   input logic             i_csr_rvalid,
   input logic             i_msg_valid,
   input logic             i_msg_vf,
   input logic [VEC_W-1:0] i_msg_vec
);
   timeunit 1ns;
   timeprecision 100ps;

   int   fail_cnt = 0;   // polled by the testbench
   logic quiet;

   assign quiet = !i_enable || i_fmask;

   // up to three messages can still drain out of the pipeline
   a_off_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      (quiet && $past(quiet, 1) && $past(quiet, 2) && $past(quiet, 3) && $past(quiet, 4))
      |-> !i_msg_valid)
   else begin
      fail_cnt++;
      $error("message sent while disabled or function masked");
   end

   a_rd_latency: assert property (@(posedge clk) disable iff (!rst_n)
      i_csr_rd |=> i_csr_rvalid)
   else begin
      fail_cnt++;
      $error("read data valid missing one cycle after read strobe");
   end

   a_rvalid_src: assert property (@(posedge clk) disable iff (!rst_n)
      i_csr_rvalid |-> $past(i_csr_rd))
   else begin
      fail_cnt++;
      $error("read data valid without a read strobe one cycle earlier");
   end

   a_vec_range: assert property (@(posedge clk) disable iff (!rst_n)
      i_msg_valid |-> (int'(i_msg_vec) < (i_msg_vf ? NUM_VF_VEC : NUM_PF_VEC)))
   else begin
      fail_cnt++;
      $error("message vector outside its table");
   end

   a_reset_quiet: assert property (@(posedge clk)
      (rst_n && (!$past(rst_n, 1) || !$past(rst_n, 2) || !$past(rst_n, 3))) |-> !i_msg_valid)
   else begin
      fail_cnt++;
      $error("message right after reset");
   end

endmodule

bind msix_top msix_assert #(
   .NUM_PF_VEC (NUM_PF_VEC),
   .NUM_VF_VEC (NUM_VF_VEC),
   .VEC_W      (VEC_W)
) msix_assert_inst (
   .clk          (clk),
   .rst_n        (rst_n),
   .i_enable     (enable),
   .i_fmask      (fmask),
   .i_csr_rd     (i_csr_rd),
   .i_csr_rvalid (o_csr_rvalid),
   .i_msg_valid  (o_msg_valid),
   .i_msg_vf     (o_msg_vf),
   .i_msg_vec    (o_msg_vec)
);

//--- tb/msix_tb.sv
/*
 * msix testbench
 * programs the PF and VF vector tables, drives interrupt requests and
 * checks every message against shadow tables and shadow pending bits
 */
module msix_tb
   import msix_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NPF   = DEF_NUM_PF_VEC;
   localparam int NVF   = DEF_NUM_VF_VEC;
   localparam int VW    = DEF_VEC_W;
   localparam int NSLOT = 1 << VW;
   localparam int TMO   = 200;   // cycles allowed per wait

   typedef struct packed {
      logic          vf;
      logic [VW-1:0] vec;
      logic [63:0]   addr;
      logic [31:0]   data;
   } msg_t;

   logic                  clk;
   logic                  rst_n;
   logic                  i_csr_wr;
   logic                  i_csr_rd;
   logic [CSR_ADDR_W-1:0] i_csr_addr;
   logic [63:0]           i_csr_wdata;
   logic [63:0]           o_csr_rdata;
   logic                  o_csr_rvalid;
   logic                  i_intr_valid;
   logic                  i_intr_vf;
   logic [VW-1:0]         i_intr_vec;
   logic                  o_msg_valid;
   logic [63:0]           o_msg_addr;
   logic [31:0]           o_msg_data;
   logic                  o_msg_vf;
   logic [VW-1:0]         o_msg_vec;

   // shadow state, indexed [vf][vec]
   logic [63:0] sh_addr [2][NSLOT];
   logic [31:0] sh_data [2][NSLOT];
   logic        sh_mask [2][NSLOT];
   logic        sh_pend [2][NSLOT];
   msg_t        exp_q [$];
   int          msg_cnt;
   logic [31:0] rng;

   msix_top msix_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //------------------------------------------------------------
   // helpers
   //------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic int vec_count(input logic vf);
      return vf ? NVF : NPF;
   endfunction

   // word address of a table entry, ctl picks the data and mask word
   function automatic logic [CSR_ADDR_W-1:0] entry_word(input logic vf, input int vec,
                                                         input logic ctl);
      int base;
      base = vf ? int'(VF_TABLE_BASE) : 0;
      return CSR_ADDR_W'(base + 2 * vec + int'(ctl));
   endfunction

   task automatic fail_now(input string what);
      $display("%s (time %0t)", what, $time);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("Error: time %0t, %s = %0h, expected %0h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic write_reg(input logic [CSR_ADDR_W-1:0] addr, input logic [63:0] data);
      @(posedge clk);
      i_csr_wr    <= 1'b1;
      i_csr_addr  <= addr;
      i_csr_wdata <= data;
      @(posedge clk);
      i_csr_wr    <= 1'b0;
   endtask

   task automatic read_reg(input logic [CSR_ADDR_W-1:0] addr, output logic [63:0] data);
      int n;
      @(posedge clk);
      i_csr_rd   <= 1'b1;
      i_csr_addr <= addr;
      @(posedge clk);
      i_csr_rd   <= 1'b0;
      n = 0;
      while (!o_csr_rvalid) begin
         @(posedge clk);
         n++;
         if (n > TMO) fail_now("register read never returned data");
      end
      data = o_csr_rdata;
   endtask

   task automatic set_ctrl(input logic en, input logic fm);
      write_reg(CTRL_ADDR, {62'b0, fm, en});
   endtask

   task automatic program_entry(input logic vf, input int vec, input logic [63:0] addr,
                                input logic [31:0] data, input logic mask);
      sh_addr[vf][vec] = addr;
      sh_data[vf][vec] = data;
      sh_mask[vf][vec] = mask;
      write_reg(entry_word(vf, vec, 1'b0), addr);
      write_reg(entry_word(vf, vec, 1'b1), {31'b0, mask, data});
   endtask

   task automatic set_mask(input logic vf, input int vec, input logic mask);
      program_entry(vf, vec, sh_addr[vf][vec], sh_data[vf][vec], mask);
   endtask

   task automatic fill_tables();
      for (int f = 0; f < 2; f++) begin
         for (int v = 0; v < vec_count(f[0]); v++) begin
            program_entry(f[0], v, {next_rand(), next_rand()}, next_rand(), 1'b0);
         end
      end
   endtask

   task automatic check_table();
      logic [63:0] rd;
      for (int f = 0; f < 2; f++) begin
         for (int v = 0; v < vec_count(f[0]); v++) begin
            read_reg(entry_word(f[0], v, 1'b0), rd);
            check_value("o_csr_rdata (table address)", rd, sh_addr[f][v]);
            read_reg(entry_word(f[0], v, 1'b1), rd);
            check_value("o_csr_rdata (table data)", rd, {31'b0, sh_mask[f][v], sh_data[f][v]});
         end
      end
   endtask

   task automatic check_pba();
      logic [63:0] rd;
      logic [63:0] exp_pf;
      logic [63:0] exp_vf;
      exp_pf = '0;
      exp_vf = '0;
      for (int v = 0; v < NPF; v++) exp_pf[v] = sh_pend[0][v];
      for (int v = 0; v < NVF; v++) exp_vf[v] = sh_pend[1][v];
      read_reg(PBA_PF_ADDR, rd);
      check_value("o_csr_rdata (PF pending)", rd, exp_pf);
      read_reg(PBA_VF_ADDR, rd);
      check_value("o_csr_rdata (VF pending)", rd, exp_vf);
   endtask

   task automatic raise_intr(input logic vf, input logic [VW-1:0] vec);
      @(posedge clk);
      i_intr_valid <= 1'b1;
      i_intr_vf    <= vf;
      i_intr_vec   <= vec;
      if (int'(vec) < vec_count(vf)) sh_pend[vf][vec] = 1'b1;  // merges with a pending bit
      @(posedge clk);
      i_intr_valid <= 1'b0;
   endtask

   task automatic expect_msg(input logic vf, input int vec);
      exp_q.push_back({vf, VW'(vec), sh_addr[vf][vec], sh_data[vf][vec]});
   endtask

   // issue order: lowest unmasked PF vector first, then VF
   task automatic release_pending();
      for (int f = 0; f < 2; f++) begin
         for (int v = 0; v < vec_count(f[0]); v++) begin
            if (sh_pend[f][v] && !sh_mask[f][v]) begin
               expect_msg(f[0], v);
               sh_pend[f][v] = 1'b0;
            end
         end
      end
   endtask

   task automatic wait_msgs(input int total);
      int n;
      n = 0;
      while (msg_cnt < total) begin
         @(posedge clk);
         n++;
         if (n > TMO) fail_now("timeout while waiting for expected messages");
      end
   endtask

   task automatic settle();
      int target;
      target = msg_cnt + exp_q.size();
      wait_msgs(target);
      idle(6);   // a late extra message trips the monitor
   endtask

   //------------------------------------------------------------
   // message monitor
   //------------------------------------------------------------
   always @(posedge clk) begin
      msg_t e;
      if (rst_n && o_msg_valid) begin
         if (exp_q.size() == 0) begin
            fail_now($sformatf("unexpected message, vf %0b vector %0d", o_msg_vf, o_msg_vec));
         end else begin
            e = exp_q.pop_front();
            check_value("o_msg_vf", 64'(o_msg_vf), 64'(e.vf));
            check_value("o_msg_vec", 64'(o_msg_vec), 64'(e.vec));
            check_value("o_msg_addr", o_msg_addr, e.addr);
            check_value("o_msg_data", 64'(o_msg_data), 64'(e.data));
            msg_cnt++;
         end
      end
   end

   always @(posedge clk) begin
      if (msix_top_inst.msix_assert_inst.fail_cnt != 0) fail_now("a bound DUT assertion failed");
   end

   //------------------------------------------------------------
   // stimulus
   //------------------------------------------------------------
   initial begin
      logic [63:0] rd;
      logic [31:0] r;
      int          n;
      int          unmapped [6];
      rst_n        = 1'b0;
      i_csr_wr     = 1'b0;
      i_csr_rd     = 1'b0;
      i_csr_addr   = '0;
      i_csr_wdata  = '0;
      i_intr_valid = 1'b0;
      i_intr_vf    = 1'b0;
      i_intr_vec   = '0;
      msg_cnt      = 0;
      rng          = 32'h2729_d94c;
      unmapped     = '{14, 15, 26, 31, 35, 63};
      for (int f = 0; f < 2; f++) begin
         for (int v = 0; v < NSLOT; v++) begin
            sh_addr[f][v] = '0;
            sh_data[f][v] = '0;
            sh_mask[f][v] = 1'b0;
            sh_pend[f][v] = 1'b0;
         end
      end
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      // reset values, table readback, unmapped words
      check_pba();
      read_reg(CTRL_ADDR, rd);
      check_value("o_csr_rdata (control)", rd, 64'd0);
      fill_tables();
      check_table();
      foreach (unmapped[i]) begin
         read_reg(CSR_ADDR_W'(unmapped[i]), rd);
         check_value("o_csr_rdata (unmapped)", rd, 64'd0);
      end
      set_ctrl(1'b1, 1'b1);
      read_reg(CTRL_ADDR, rd);
      check_value("o_csr_rdata (control)", rd, 64'd3);

      // single PF request, three edges from sample to message
      set_ctrl(1'b1, 1'b0);
      @(posedge clk);
      i_intr_valid <= 1'b1;
      i_intr_vf    <= 1'b0;
      i_intr_vec   <= VW'(3);
      expect_msg(1'b0, 3);
      n = 0;
      do begin
         @(posedge clk);
         i_intr_valid <= 1'b0;
         n++;
         if (n > TMO) fail_now("single PF request produced no message");
      end while (!o_msg_valid);
      // sample edge is 1, rise on edge 4, seen high on edge 5
      check_value("message latency in cycles", 64'(n), 64'd5);
      settle();

      // VF message, then PF before VF when both pending
      raise_intr(1'b1, VW'(2));
      release_pending();
      settle();
      set_ctrl(1'b1, 1'b1);
      raise_intr(1'b1, VW'(3));
      raise_intr(1'b1, VW'(0));
      raise_intr(1'b0, VW'(4));
      raise_intr(1'b0, VW'(1));
      raise_intr(1'b0, VW'(4));   // duplicate
      idle(10);
      check_pba();
      set_ctrl(1'b1, 1'b0);
      release_pending();
      settle();

      // masked vectors stay pending until unmasked
      set_mask(1'b0, 5, 1'b1);
      raise_intr(1'b0, VW'(5));
      release_pending();
      idle(10);
      check_pba();
      set_mask(1'b0, 5, 1'b0);
      release_pending();
      settle();
      set_mask(1'b1, 4, 1'b1);
      raise_intr(1'b1, VW'(4));
      raise_intr(1'b0, VW'(0));
      release_pending();
      settle();
      check_pba();
      set_mask(1'b1, 4, 1'b0);
      release_pending();
      settle();

      // disabled, nothing leaves until enable
      set_ctrl(1'b0, 1'b0);
      raise_intr(1'b0, VW'(6));
      raise_intr(1'b0, VW'(0));
      raise_intr(1'b1, VW'(1));
      idle(10);
      check_pba();
      set_ctrl(1'b1, 1'b0);
      release_pending();
      settle();

      // random burst with duplicates and out of range vectors
      fill_tables();
      check_table();
      set_ctrl(1'b0, 1'b0);
      for (int i = 0; i < 24; i++) begin
         r = next_rand();
         raise_intr(r[0], r[VW:1]);
      end
      check_pba();
      set_ctrl(1'b1, 1'b0);
      release_pending();
      settle();

      // out of range only
      set_ctrl(1'b0, 1'b0);
      raise_intr(1'b0, VW'(7));
      raise_intr(1'b1, VW'(5));
      raise_intr(1'b1, VW'(6));
      raise_intr(1'b1, VW'(7));
      check_pba();
      set_ctrl(1'b1, 1'b0);
      release_pending();
      settle();

      if (msix_top_inst.msix_assert_inst.fail_cnt == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("bound DUT assertions reported failures");
         $display("TEST FAILED");
         $fatal(1);
      end
   end

endmodule

//--- verilog.f
verilog/msix_pkg.sv
verilog/msix_lookup_if.sv
verilog/msix_csr.sv
verilog/msix_pending.sv
verilog/msix_ctrl.sv
verilog/msix_table_lookup.sv
verilog/msix_top.sv
tb/msix_assert.sv
tb/msix_tb.sv

//--- Makefile
# Verilator flow for the MSI-X message generator

VERILATOR  ?= verilator
TOP        := msix_tb
RTL_TOP    := msix_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
RUN_ARGS   := +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
sim: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
